/* tcdm_addr_decode.sv */
// pure combinational range match; overlapping ranges resolve to the highest rule, no match gives 0
`timescale 1ns/1ps

module tcdm_addr_decode import tcdm_pkg::*; #(
  parameter int unsigned                N_RULES  = 3,
  parameter addr_range_t [0:N_RULES-1]  ADDR_MAP = '0
) (
  input  addr_t     addr_i,
  output rule_idx_t idx_o
);

  logic [N_RULES-1:0] hit;  // one bit per rule

  // range compare per rule
  always_comb begin
    for (int i = 0; i < N_RULES; i++) begin
      hit[i] = (addr_i >= ADDR_MAP[i].start_addr) &&
               (addr_i <  ADDR_MAP[i].end_addr);
    end
  end

  // later rules overwrite earlier ones, so the highest match wins
  always_comb begin
    idx_o = '0;  // unmapped by default
    for (int i = 0; i < N_RULES; i++) begin
      if (hit[i]) begin
        idx_o = rule_to_idx(i);
      end
    end
  end

endmodule

/* tcdm_bank.sv */
// BANK_WORDS must be a power of two; upper address bits alias; reset zeroes every word
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  req_t req_i,
  output rsp_t rsp_o
);

  localparam int unsigned AW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  data_t           mem [BANK_WORDS];
  logic [AW-1:0]   word_idx;
  data_t           rdata_q;
  logic            valid_q;

  assign word_idx = req_i.addr[AW+1:2];  // drop byte offset, wrap at bank size

  // byte-lane writes, read data registered on every request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        mem[w] <= '0;  // unwritten words read as zero
      end
      rdata_q <= '0;
    end else if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];  // old word on a write, ignored upstream
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.req;  // every request is granted at once
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.gnt   = req_i.req;  // never stalls
    rsp_o.valid = valid_q;
    rsp_o.rdata = rdata_q;
  end

endmodule

/* tcdm_id_fifo.sv */
// index FIFO; push when full and pop when empty are ignored, head word is valid only when not empty
`timescale 1ns/1ps

module tcdm_id_fifo import tcdm_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  logic      pop_i,
  input  rule_idx_t data_i,
  output rule_idx_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  rule_idx_t         mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push_en, pop_en;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;
  assign data_o  = mem[rd_ptr_q];  // head, visible the cycle after the push

  // storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* tcdm_pkg.sv */
// shared TCDM types; rule indices are one-based with 0 meaning unmapped, at most N_RULES_MAX rules
package tcdm_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one bit per byte lane

  // request as seen by one port
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } req_t;

  // response from one port
  typedef struct packed {
    logic  gnt;
    logic  valid;
    logic  err;
    data_t rdata;
  } rsp_t;

  // start is inclusive, end is exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } addr_range_t;

  localparam int unsigned N_RULES_MAX = 8;

  // room for N_RULES_MAX rules plus the no-match value
  typedef logic [$clog2(N_RULES_MAX + 1)-1:0] rule_idx_t;

  // zero-based rule number to one-based index
  function automatic rule_idx_t rule_to_idx(input int unsigned rule);
    return rule_idx_t'(rule + 1);
  endfunction

endpackage

/* tcdm_router.sv */
// single master only; banks must answer exactly one cycle after grant and in order, no stalls
`timescale 1ns/1ps

module tcdm_router import tcdm_pkg::*; #(
  parameter int unsigned                N_RULES    = 3,
  parameter addr_range_t [0:N_RULES-1]  ADDR_MAP   = '0,
  parameter int unsigned                FIFO_DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  req_t master_req_i,
  output rsp_t master_rsp_o,
  output req_t bank_req_o [N_RULES],
  input  rsp_t bank_rsp_i [N_RULES]
);

  rule_idx_t          sel_idx;   // target of the current request
  rule_idx_t          head_idx;  // target of the oldest outstanding request
  logic               fifo_full, fifo_empty;
  logic [N_RULES-1:0] bank_gnt, bank_valid;
  logic               err_gnt;
  logic               err_pending_q;
  logic               req_gnt;
  logic               rsp_valid;

  tcdm_addr_decode #(
    .N_RULES  (N_RULES),
    .ADDR_MAP (ADDR_MAP)
  ) i_addr_decode (
    .addr_i (master_req_i.addr),
    .idx_o  (sel_idx)
  );

  // remembers where each granted request went
  tcdm_id_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_gnt),
    .pop_i   (rsp_valid),
    .data_i  (sel_idx),
    .data_o  (head_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // steer to the selected bank only, nothing while the FIFO is full
  always_comb begin
    for (int i = 0; i < N_RULES; i++) begin
      bank_req_o[i] = '0;
      if (!fifo_full && sel_idx == rule_to_idx(i)) begin
        bank_req_o[i] = master_req_i;
      end
      bank_gnt[i]   = bank_rsp_i[i].gnt;
      bank_valid[i] = bank_rsp_i[i].valid;
    end
  end

  // unmapped requests are granted here
  assign err_gnt = master_req_i.req & ~fifo_full & (sel_idx == '0);
  assign req_gnt = (|bank_gnt) | err_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_pending_q <= 1'b0;
    end else begin
      err_pending_q <= err_gnt;  // error answer one cycle later
    end
  end

  assign rsp_valid = (|bank_valid) | err_pending_q;

  // response follows the FIFO head, not the current request
  always_comb begin
    master_rsp_o       = '0;
    master_rsp_o.gnt   = req_gnt;
    master_rsp_o.valid = rsp_valid;
    master_rsp_o.err   = rsp_valid & ~fifo_empty & (head_idx == '0);
    for (int i = 0; i < N_RULES; i++) begin
      if (head_idx == rule_to_idx(i)) begin
        master_rsp_o.rdata = bank_rsp_i[i].rdata;
      end
    end
  end

endmodule

/* tcdm_subsys.f */
tcdm_pkg.sv
tcdm_addr_decode.sv
tcdm_id_fifo.sv
tcdm_router.sv
tcdm_bank.sv
tcdm_subsys.sv
tcdm_tb_clock.sv
tcdm_tb.sv

/* tcdm_subsys.sv */
// one master, N_RULES banks; ADDR_MAP needs one entry per bank and sizes each range to BANK_WORDS
`timescale 1ns/1ps

module tcdm_subsys import tcdm_pkg::*; #(
  parameter int unsigned                N_RULES    = 3,
  parameter addr_range_t [0:N_RULES-1]  ADDR_MAP   = '{
    '{start_addr: 32'h0000_0000, end_addr: 32'h0000_0400},
    '{start_addr: 32'h0000_1000, end_addr: 32'h0000_1400},
    '{start_addr: 32'h0000_2000, end_addr: 32'h0000_2400}
  },
  parameter int unsigned                BANK_WORDS = 256,
  parameter int unsigned                FIFO_DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  req_t master_req_i,
  output rsp_t master_rsp_o
);

  req_t bank_req [N_RULES];  // router to banks
  rsp_t bank_rsp [N_RULES];

  tcdm_router #(
    .N_RULES    (N_RULES),
    .ADDR_MAP   (ADDR_MAP),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .master_req_i (master_req_i),
    .master_rsp_o (master_rsp_o),
    .bank_req_o   (bank_req),
    .bank_rsp_i   (bank_rsp)
  );

  // one bank per address rule
  for (genvar i = 0; i < N_RULES; i++) begin : g_bank
    tcdm_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) i_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (bank_req[i]),
      .rsp_o  (bank_rsp[i])
    );
  end

endmodule

/* tcdm_tb.sv */
// reads tcdm_testdata.txt from the run directory; every grant must give a valid response one cycle later
`timescale 1ns/1ps

module tcdm_tb import tcdm_pkg::*; ();

  localparam int unsigned RESET_CYCLES    = 16;
  localparam int unsigned CYCLES_PER_LINE = 20;

  typedef struct packed {
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
    logic  b2b;  // issue in the cycle right after the previous grant
  } txn_t;

  logic clk;
  logic rst_n;
  req_t master_req;
  rsp_t master_rsp;

  txn_t        txns [$];
  txn_t        exp_q [$];  // granted, response still due
  int unsigned mismatch_cnt  = 0;
  int unsigned other_cnt     = 0;
  int unsigned cycle_cnt     = 0;
  int unsigned timeout_limit = 0;

  tcdm_tb_clock #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_subsys DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .master_req_i (master_req),
    .master_rsp_o (master_rsp)
  );

  task automatic check_rsp_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_rsp_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // gnt and valid levels
  task automatic check_rsp_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a, be, wd, rd, er, bb;
    txn_t        t;
    fd = $fopen("tcdm_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tcdm_testdata.txt, no transactions run");
      other_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
      n = $sscanf(line, "%c %h %h %h %h %h %h", op, a, be, wd, rd, er, bb);
      if (n != 7) begin
        $display("malformed data line skipped: %s", line);
        other_cnt++;
      end else begin
        t.we        = (op == "W");
        t.be        = strb_t'(be);
        t.addr      = a;
        t.wdata     = wd;
        t.exp_rdata = rd;
        t.exp_err   = er[0];
        t.b2b       = bb[0];
        txns.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_txn(input txn_t t);
    master_req.req   = 1'b1;
    master_req.we    = t.we;
    master_req.be    = t.be;
    master_req.addr  = t.addr;
    master_req.wdata = t.wdata;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (timeout_limit != 0 && cycle_cnt > timeout_limit) begin
      $display("timeout after %0d cycles, transactions did not complete", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned idx;
    int unsigned idle_left;
    int unsigned drain;
    int unsigned seed;
    logic        active;
    logic        due;
    txn_t        cur;
    txn_t        exp_t;
    idx        = 0;
    drain      = 2;
    active     = 1'b0;
    due        = 1'b0;
    cur        = '0;
    exp_t      = '0;
    master_req = '0;
    seed       = 32'h3c04;
    void'($urandom(seed));
    load_testdata();
    timeout_limit = RESET_CYCLES + CYCLES_PER_LINE * txns.size();

    // outputs stay quiet through reset
    @(negedge clk);
    while (!rst_n) begin
      check_rsp_flag("master_rsp_o.gnt", master_rsp.gnt, 1'b0);
      check_rsp_flag("master_rsp_o.valid", master_rsp.valid, 1'b0);
      @(negedge clk);
    end

    idle_left = $urandom % 3;
    while (idx < txns.size() || active || due || drain > 0) begin
      @(posedge clk);
      #2;
      if (!active && idx < txns.size()) begin
        if (idle_left > 0) begin
          idle_left--;
        end else begin
          cur    = txns[idx];
          active = 1'b1;
        end
      end
      if (active) drive_txn(cur);
      else master_req = '0;

      @(negedge clk);  // mid-cycle sample
      if (master_rsp.valid) begin
        if (!due || exp_q.size() == 0) begin
          $display("unexpected valid response at %0t with no grant the cycle before", $time);
          other_cnt++;
        end else begin
          exp_t = exp_q.pop_front();
          check_rsp_err("master_rsp_o.err", master_rsp.err, exp_t.exp_err);
          if (!exp_t.we) check_rsp_data("master_rsp_o.rdata", master_rsp.rdata, exp_t.exp_rdata);
        end
      end else if (due) begin
        $display("no valid response at %0t one cycle after the grant", $time);
        other_cnt++;
        if (exp_q.size() > 0) exp_t = exp_q.pop_front();
      end
      due = 1'b0;

      if (active) begin
        if (master_rsp.gnt) begin
          exp_q.push_back(cur);
          due    = 1'b1;
          active = 1'b0;
          idx++;
          if (idx < txns.size()) idle_left = txns[idx].b2b ? 0 : $urandom % 3;
        end
      end else begin
        check_rsp_flag("master_rsp_o.gnt", master_rsp.gnt, 1'b0);  // idle bus
        if (idx >= txns.size() && drain > 0) drain--;
      end
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tcdm_tb_clock.sv */
// free-running clock from time zero; reset is released shortly after the last counted rising edge
`timescale 1ns/1ps

module tcdm_tb_clock #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;  // off the edge
  end

endmodule

/* tcdm_testdata.txt */
# columns: op (R/W) addr be wdata exp_rdata exp_err b2b, all hex
# b2b 1 issues the line right after the previous grant, 0 allows random idle cycles
W 00000010 f 11223344 00000000 0 0
W 00001010 f 55667788 00000000 0 0
W 00002010 f 99aabbcc 00000000 0 0
R 00000010 f 00000000 11223344 0 0
R 00001010 f 00000000 55667788 0 0
R 00002010 f 00000000 99aabbcc 0 0
W 00001020 f deadbeef 00000000 0 0
W 00001020 5 00110022 00000000 0 0
R 00001020 f 00000000 de11be22 0 0
R 00000800 f 00000000 00000000 1 0
W 00001800 f 12345678 00000000 1 0
R 00000010 f 00000000 11223344 0 1
W 000003fc f a5a5a5a5 00000000 0 0
W 000023fc f 5a5a5a5a 00000000 0 1
R 000003fc f 00000000 a5a5a5a5 0 1
R 000023fc f 00000000 5a5a5a5a 0 1
R 00000010 f 00000000 11223344 0 1
R 00002010 f 00000000 99aabbcc 0 1
R 00001020 f 00000000 de11be22 0 1
R 00000800 f 00000000 00000000 1 1
R 00001010 f 00000000 55667788 0 1
R 000013fc f 00000000 00000000 0 0
